// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mmu
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell cat sim.f)

.PHONY: all run clean

all: run

$(SIM_BIN): sim.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: mmu.sv
`timescale 1ns/1ps

module mmu #(
    parameter int WAY_NUM   = 4,
    parameter int IDX_WIDTH = 5
) (
    input  logic                          clk,
    input  logic                          rstn,

    // client
    input  logic                          req,
    input  logic [mmu_pkg::VPN_WIDTH-1:0] req_vpn,
    output logic                          req_ready,
    output logic                          resp_valid,
    output logic [mmu_pkg::PPN_WIDTH-1:0] resp_ppn,
    output logic                          resp_fault,

    // page table walk over wishbone
    input  logic [mmu_pkg::ADR_WIDTH-1:0] pt_base,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic [mmu_pkg::ADR_WIDTH-1:0] wb_adr,
    input  logic [mmu_pkg::PTE_WIDTH-1:0] wb_dat_i,
    input  logic                          wb_ack
);

    tlb_if tlb_bus ();

    xlate_ctrl ctrl_i (
        .clk        (clk),
        .rstn       (rstn),
        .tbus       (tlb_bus.ctrl),
        .req        (req),
        .req_vpn    (req_vpn),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_ppn   (resp_ppn),
        .resp_fault (resp_fault),
        .pt_base    (pt_base),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack)
    );

    tlb #(
        .WAY_NUM   (WAY_NUM),
        .IDX_WIDTH (IDX_WIDTH)
    ) tlb_i (
        .clk  (clk),
        .rstn (rstn),
        .bus  (tlb_bus.tlb)
    );

endmodule

// File: mmu_input.txt
# P <pte word address, hex> <pte value, hex>
# T <test name> <vpn, hex> <expected ppn, hex> <expected fault> <expected walk>
P 012 12345001
P 055 0abcd000
P 0ff fffff7fd
P 003 0a003001
P 023 0b023001
P 043 0c043001
P 063 0d063001
P 083 0e083001
T cold_miss     012 12345 0 1
T hit_repeat    012 12345 0 0
T fault_first   055 00000 1 1
T fault_again   055 00000 1 1
T flags_miss    0ff fffff 0 1
T unmapped      0a0 00000 1 1
T lru_fill_a    003 0a003 0 1
T lru_fill_b    023 0b023 0 1
T lru_fill_c    043 0c043 0 1
T lru_fill_d    063 0d063 0 1
T lru_touch_a   003 0a003 0 0
T lru_fill_e    083 0e083 0 1
T lru_hit_a     003 0a003 0 0
T lru_hit_c     043 0c043 0 0
T lru_hit_d     063 0d063 0 0
T lru_hit_e     083 0e083 0 0
T lru_miss_b    023 0b023 0 1

// File: mmu_pkg.sv
package mmu_pkg;

    // page numbers and bus widths
    localparam int VPN_WIDTH  = 20;
    localparam int PPN_WIDTH  = 20;
    localparam int ADR_WIDTH  = 32;
    localparam int PTE_WIDTH  = 32;

    // reserved bits between ppn and the valid bit
    localparam int FLAG_WIDTH = PTE_WIDTH - PPN_WIDTH - 1;

    // one page table entry, as read from memory
    typedef struct packed {
        logic [PPN_WIDTH-1:0]  ppn;
        logic [FLAG_WIDTH-1:0] flags; // unused for now
        logic                  valid; // bit 0
    } pte_t;

endpackage

// File: mmu_props.sv
`timescale 1ns/1ps

module mmu_props (
    input logic                          clk,
    input logic                          rstn,
    input logic                          req_ready,
    input logic                          resp_valid,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic [mmu_pkg::ADR_WIDTH-1:0] wb_adr,
    input logic                          wb_ack
);

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rstn)
        wb_stb |-> wb_cyc)
        else $error("wb_stb is high while wb_cyc is low");

    // address held until the slave acks
    a_adr_held: assert property (@(posedge clk) disable iff (!rstn)
        wb_stb && !wb_ack |=> $stable(wb_adr))
        else $error("wb_adr changed before the read was acked");

    a_busy_walk: assert property (@(posedge clk) disable iff (!rstn)
        wb_cyc |-> !req_ready)
        else $error("req_ready is high during a page walk");

    a_resp_pulse: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |=> !resp_valid)
        else $error("resp_valid stayed high for two cycles");

endmodule

// File: sim.f
mmu_pkg.sv
tlb_if.sv
tlb_sram.sv
tlb.sv
xlate_ctrl.sv
mmu.sv
mmu_props.sv
tb_mmu.sv

// File: tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu;

    localparam int          SEED            = 93088;
    localparam int          RESET_CYCLES    = 5;
    localparam int          CYCLES_PER_TEST = 40;
    localparam int          HIT_LATENCY     = 2; // accept edge to sampled response
    localparam int          PT_AW           = 10;
    localparam logic [31:0] PT_BASE         = 32'h0004_0000;

    logic                          clk;
    logic                          rstn;
    logic                          req;
    logic [mmu_pkg::VPN_WIDTH-1:0] req_vpn;
    logic                          req_ready;
    logic                          resp_valid;
    logic [mmu_pkg::PPN_WIDTH-1:0] resp_ppn;
    logic                          resp_fault;
    logic [mmu_pkg::ADR_WIDTH-1:0] pt_base;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic [mmu_pkg::ADR_WIDTH-1:0] wb_adr;
    logic [mmu_pkg::PTE_WIDTH-1:0] wb_dat_i;
    logic                          wb_ack;

    logic [31:0]                   pt_mem [2**PT_AW];
    string                         test_name [$];
    logic [mmu_pkg::VPN_WIDTH-1:0] test_vpn [$];
    logic [mmu_pkg::PPN_WIDTH-1:0] test_ppn [$];
    logic                          test_fault [$];
    logic                          test_walk [$];
    int                            cur_test;
    int                            errors;
    int                            failed_tests;
    int                            cycle_cnt;
    int                            cycle_limit = 0;

    mmu #(.WAY_NUM(4), .IDX_WIDTH(5)) dut_i (.*);

    bind mmu mmu_props props_i (
        .clk(clk), .rstn(rstn), .req_ready(req_ready), .resp_valid(resp_valid),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
                $display("timeout: no response from the DUT after %0d cycles", cycle_cnt);
                $display("Finished with errors");
                $finish;
            end
        end
    end

    // four bytes per page table entry
    function automatic logic [31:0] pte_addr(input logic [mmu_pkg::VPN_WIDTH-1:0] vpn);
        return pt_base + 32'(vpn) * 32'd4;
    endfunction

    task automatic load_data();
        int    fd;
        int    fault;
        int    walk;
        string line;
        string name;
        logic [31:0] adr;
        logic [31:0] val;
        logic [mmu_pkg::VPN_WIDTH-1:0] vpn;
        logic [mmu_pkg::PPN_WIDTH-1:0] ppn;
        for (int i = 0; i < 2**PT_AW; i++) begin
            pt_mem[i[PT_AW-1:0]] = {12'hbad, i[11:0], 8'h00}; // valid bit clear
        end
        fd = $fopen("mmu_input.txt", "r");
        if (fd == 0) begin
            $display("could not open mmu_input.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) == "P" && $sscanf(line, "P %h %h", adr, val) == 2) begin
                pt_mem[adr[PT_AW-1:0]] = val;
            end else if (line.getc(0) == "T" &&
                         $sscanf(line, "T %s %h %h %d %d", name, vpn, ppn, fault, walk) == 5) begin
                test_name.push_back(name);
                test_vpn.push_back(vpn);
                test_ppn.push_back(ppn);
                test_fault.push_back(fault != 0);
                test_walk.push_back(walk != 0);
            end
        end
        $fclose(fd);
    endtask

    // page table slave, random wait states before each ack
    task automatic serve_read();
        int          waits;
        logic [31:0] word;
        waits = int'($urandom % 4);
        assert (wb_adr == pte_addr(test_vpn[cur_test])) else begin
            $display("mismatch %s wb_adr expected %h actual %h", test_name[cur_test],
                     pte_addr(test_vpn[cur_test]), wb_adr);
            errors++;
        end
        word = (wb_adr - pt_base) >> 2;
        repeat (waits) @(posedge clk);
        wb_dat_i <= pt_mem[word[PT_AW-1:0]];
        wb_ack   <= 1'b1;
        @(posedge clk);
        wb_ack   <= 1'b0;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (rstn && wb_cyc && wb_stb && !wb_ack) begin
                serve_read();
            end
        end
    end

    task automatic run_test(input int t);
        int   start_errs;
        int   lat;
        logic walked;
        start_errs = errors;
        cur_test   = t;
        req     <= 1'b1;
        req_vpn <= test_vpn[t];
        do @(posedge clk); while (!req_ready); // accepted on this edge
        req <= 1'b0;
        lat    = 0;
        walked = 1'b0;
        do begin
            @(posedge clk);
            lat++;
            if (wb_cyc) walked = 1'b1;
        end while (!resp_valid);
        assert (resp_ppn == test_ppn[t]) else begin
            $display("mismatch %s ppn expected %h actual %h", test_name[t], test_ppn[t], resp_ppn);
            errors++;
        end
        assert (resp_fault == test_fault[t]) else begin
            $display("mismatch %s fault expected %0b actual %0b", test_name[t], test_fault[t],
                     resp_fault);
            errors++;
        end
        assert (walked == test_walk[t]) else begin
            $display("mismatch %s walk expected %0b actual %0b", test_name[t], test_walk[t], walked);
            errors++;
        end
        if (!test_walk[t]) begin
            assert (lat == HIT_LATENCY) else begin
                $display("mismatch %s hit latency expected %0d actual %0d", test_name[t],
                         HIT_LATENCY, lat);
                errors++;
            end
        end
        if (errors != start_errs) failed_tests++;
        $display("test %-12s %s after %0d cycles", test_name[t],
                 (errors == start_errs) ? "passed" : "FAILED", lat);
    endtask

    initial begin
        void'($urandom(SEED));
        rstn         = 1'b0;
        req          = 1'b0;
        req_vpn      = '0;
        pt_base      = PT_BASE;
        wb_ack       = 1'b0;
        wb_dat_i     = '0;
        errors       = 0;
        failed_tests = 0;
        cur_test     = 0;
        load_data();
        cycle_limit = test_name.size() * CYCLES_PER_TEST;
        assert (test_name.size() > 0) else begin
            $display("no tests were read from mmu_input.txt");
            errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        for (int t = 0; t < test_name.size(); t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d errors", test_name.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: tlb.sv
`timescale 1ns/1ps

module tlb #(
    parameter int WAY_NUM   = 4,
    parameter int IDX_WIDTH = 5
) (
    input  logic clk,
    input  logic rstn,
    tlb_if.tlb   bus
);

    localparam int SETS      = 2**IDX_WIDTH;
    localparam int TAG_WIDTH = mmu_pkg::VPN_WIDTH - IDX_WIDTH;
    localparam int OW        = $clog2(WAY_NUM);
    localparam logic [OW-1:0] MRU = OW'(WAY_NUM - 1);

    typedef logic [TAG_WIDTH-1:0] tlb_tag_t;

    logic [IDX_WIDTH-1:0] idx;
    tlb_tag_t             tag;
    logic                 rd;
    logic                 wr;

    // lookup state, one cycle behind the read
    logic                 rd_q;
    logic [IDX_WIDTH-1:0] idx_q;
    tlb_tag_t             tag_q;
    logic [WAY_NUM-1:0]   way_valid_q;

    logic [SETS-1:0]      valid_q [WAY_NUM];
    logic [OW-1:0]        order_q [WAY_NUM][SETS]; // 0 is lru

    logic [WAY_NUM-1:0]   hit;
    logic [WAY_NUM-1:0]   victim;
    tlb_tag_t             tag_rd [WAY_NUM];
    mmu_pkg::pte_t        pte_rd [WAY_NUM];

    logic                 promote;
    logic [IDX_WIDTH-1:0] sel_set;
    logic [WAY_NUM-1:0]   sel_way;
    logic [OW-1:0]        sel_order;

    assign idx = bus.vpn[IDX_WIDTH-1:0];
    assign tag = bus.vpn[mmu_pkg::VPN_WIDTH-1:IDX_WIDTH];
    assign rd  = bus.cs && !bus.we;
    assign wr  = bus.cs && bus.we;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_q        <= 1'b0;
            way_valid_q <= '0;
        end else begin
            rd_q <= rd;
            if (rd) begin
                for (int w = 0; w < WAY_NUM; w++) begin
                    way_valid_q[w] <= valid_q[w][idx];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            tag_q <= tag;
            idx_q <= idx;
        end
    end

    assign bus.pte_hit = |hit;

    always_comb begin
        bus.pte_out = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            bus.pte_out = bus.pte_out | (pte_rd[w] & {mmu_pkg::PTE_WIDTH{hit[w]}});
        end
    end

    // a fill and a hit both move one way to mru
    assign promote = wr || bus.pte_hit;
    assign sel_set = wr ? idx : idx_q;
    assign sel_way = wr ? victim : hit;

    always_comb begin
        sel_order = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (sel_way[w]) begin
                sel_order = sel_order | order_q[w][sel_set];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                valid_q[w] <= '0;
                for (int s = 0; s < SETS; s++) begin
                    order_q[w][s] <= OW'(w);
                end
            end
        end else if (promote) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                if (sel_way[w]) begin
                    order_q[w][sel_set] <= MRU;
                    if (wr) begin
                        valid_q[w][sel_set] <= 1'b1;
                    end
                end else if (order_q[w][sel_set] > sel_order) begin
                    order_q[w][sel_set] <= order_q[w][sel_set] - 1'b1; // close the gap
                end
            end
        end
    end

    for (genvar g = 0; g < WAY_NUM; g++) begin : g_way
        assign victim[g] = wr && (order_q[g][idx] == '0);
        assign hit[g]    = rd_q && way_valid_q[g] && (tag_rd[g] == tag_q);

        tlb_sram #(
            .payload_t  (tlb_tag_t),
            .ADDR_WIDTH (IDX_WIDTH)
        ) tag_ram_i (
            .clk  (clk),
            .cs   (bus.cs),
            .we   (bus.we && victim[g]),
            .addr (idx),
            .din  (tag),
            .dout (tag_rd[g])
        );

        tlb_sram #(
            .payload_t  (mmu_pkg::pte_t),
            .ADDR_WIDTH (IDX_WIDTH)
        ) pte_ram_i (
            .clk  (clk),
            .cs   (bus.cs),
            .we   (bus.we && victim[g]),
            .addr (idx),
            .din  (bus.pte_in),
            .dout (pte_rd[g])
        );
    end

endmodule

// File: tlb_if.sv
`timescale 1ns/1ps

interface tlb_if;

    logic                             cs;
    logic                             we;
    logic [mmu_pkg::VPN_WIDTH-1:0]    vpn;
    mmu_pkg::pte_t                    pte_in;
    logic                             pte_hit;  // one cycle after a read
    mmu_pkg::pte_t                    pte_out;

    modport ctrl (
        output cs,
        output we,
        output vpn,
        output pte_in,
        input  pte_hit,
        input  pte_out
    );

    modport tlb (
        input  cs,
        input  we,
        input  vpn,
        input  pte_in,
        output pte_hit,
        output pte_out
    );

endinterface

// File: tlb_sram.sv
`timescale 1ns/1ps

module tlb_sram #(
    parameter type payload_t  = logic [31:0],
    parameter int  ADDR_WIDTH = 5
) (
    input  logic                  clk,
    input  logic                  cs,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  payload_t              din,
    output payload_t              dout
);

    // stand-in for a memory macro
    payload_t mem [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr]; // registered read
            end
        end
    end

endmodule

// File: xlate_ctrl.sv
`timescale 1ns/1ps

module xlate_ctrl (
    input  logic                          clk,
    input  logic                          rstn,
    tlb_if.ctrl                           tbus,

    input  logic                          req,
    input  logic [mmu_pkg::VPN_WIDTH-1:0] req_vpn,
    output logic                          req_ready,
    output logic                          resp_valid,
    output logic [mmu_pkg::PPN_WIDTH-1:0] resp_ppn,
    output logic                          resp_fault,

    input  logic [mmu_pkg::ADR_WIDTH-1:0] pt_base,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic [mmu_pkg::ADR_WIDTH-1:0] wb_adr,
    input  logic [mmu_pkg::PTE_WIDTH-1:0] wb_dat_i,
    input  logic                          wb_ack
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WALK,
        S_FILL,
        S_RESPOND
    } state_t;

    state_t                          state;
    state_t                          state_nx;
    logic                            accept;
    logic [mmu_pkg::VPN_WIDTH-1:0]   vpn_q;
    mmu_pkg::pte_t                   pte_q;
    mmu_pkg::pte_t                   pte_bus;
    logic [mmu_pkg::ADR_WIDTH-1:0]   pt_off;

    assign accept  = req && req_ready;
    assign pte_bus = wb_dat_i;

    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    state_nx = S_LOOKUP;
                end
            end
            S_LOOKUP: state_nx = tbus.pte_hit ? S_IDLE : S_WALK;
            S_WALK: begin
                if (wb_ack) begin
                    state_nx = pte_bus.valid ? S_FILL : S_RESPOND;
                end
            end
            S_FILL:    state_nx = S_IDLE;
            S_RESPOND: state_nx = S_IDLE; // fault, nothing cached
            default:   state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= S_IDLE;
            req_ready  <= 1'b0;
            resp_valid <= 1'b0;
            wb_cyc     <= 1'b0;
        end else begin
            state      <= state_nx;
            req_ready  <= (state_nx == S_IDLE);
            wb_cyc     <= (state_nx == S_WALK);  // drops after the ack cycle
            resp_valid <= (state == S_LOOKUP && tbus.pte_hit) ||
                          (state == S_FILL) || (state == S_RESPOND);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            vpn_q <= req_vpn;
        end
        if (state == S_WALK && wb_ack) begin
            pte_q <= pte_bus;
        end
        case (state)
            S_LOOKUP:  resp_ppn <= tbus.pte_out.ppn;
            S_FILL:    resp_ppn <= pte_q.ppn;
            default:   resp_ppn <= '0;
        endcase
        resp_fault <= (state == S_RESPOND);
    end

    // tlb read in the accept cycle, write in the fill cycle
    assign tbus.cs     = accept || (state == S_FILL);
    assign tbus.we     = (state == S_FILL);
    assign tbus.vpn    = (state == S_IDLE) ? req_vpn : vpn_q;
    assign tbus.pte_in = pte_q;

    // byte address of the pte, four bytes per entry
    assign pt_off = {{(mmu_pkg::ADR_WIDTH - mmu_pkg::VPN_WIDTH - 2){1'b0}}, vpn_q, 2'b00};
    assign wb_adr = pt_base + pt_off;
    assign wb_stb = wb_cyc;

endmodule
